/* include/exe_config.svh */
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// --------------------------------------------------
// Core widths
// --------------------------------------------------

// Data and address width
`define XLEN 32

// Register file index width
`define REG_ADR_W 5

// --------------------------------------------------
// Data memory
// --------------------------------------------------

// Depth in 32-bit words
`define DMEM_WORDS 256

`endif

/* source/exe_pkg.sv */
`include "exe_config.svh"

package exe_pkg;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic [`XLEN-1:0]      data_t;
  typedef logic [`REG_ADR_W-1:0] reg_adr_t;
  typedef logic [2:0]            size_t;
  typedef logic [3:0]            unit_t;
  typedef logic [14:0]           op_t;
  typedef logic [3:0]            be_t;

  // Access size encoding
  localparam size_t SIZE_B = 3'd0;
  localparam size_t SIZE_H = 3'd1;
  localparam size_t SIZE_W = 3'd2;

  // One-hot unit select bits
  localparam int UNIT_ALU = 0;
  localparam int UNIT_SFT = 1;
  localparam int UNIT_BU  = 2;
  localparam int UNIT_LSU = 3;

  // One-hot operation bits, grouped by unit
  localparam int OP_ADD  = 0;
  localparam int OP_SUB  = 1;
  localparam int OP_AND  = 2;
  localparam int OP_OR   = 3;
  localparam int OP_XOR  = 4;
  localparam int OP_SLT  = 5;
  localparam int OP_SLL  = 6;
  localparam int OP_SRL  = 7;
  localparam int OP_SRA  = 8;
  localparam int OP_BEQ  = 9;
  localparam int OP_BNE  = 10;
  localparam int OP_BLT  = 11;
  localparam int OP_BGE  = 12;
  localparam int OP_JAL  = 13;
  localparam int OP_JALR = 14;
  // Shares its bit with JALR, only decoded inside the LSU path
  localparam int OP_ST   = 14;

endpackage

/* source/alu.sv */
`timescale 1ns/10ps

module alu (
  input  logic           alu_en_i,
  input  exe_pkg::data_t rs1_i,
  input  exe_pkg::data_t rs2_i,
  input  logic           unsign_i,
  input  exe_pkg::op_t   op_i,
  output exe_pkg::data_t data_o
);

  import exe_pkg::*;

  logic  lt;
  data_t res;

  // Set-less-than comparison, signed unless unsign_i
  always_comb begin
    if (unsign_i) begin
      lt = rs1_i < rs2_i;
    end else begin
      lt = $signed(rs1_i) < $signed(rs2_i);
    end
  end

  // --------------------------------------------------
  // Operation select
  // --------------------------------------------------
  always_comb begin
    res = '0;
    if (op_i[OP_ADD]) begin
      res = rs1_i + rs2_i;
    end else if (op_i[OP_SUB]) begin
      res = rs1_i - rs2_i;
    end else if (op_i[OP_AND]) begin
      res = rs1_i & rs2_i;
    end else if (op_i[OP_OR]) begin
      res = rs1_i | rs2_i;
    end else if (op_i[OP_XOR]) begin
      res = rs1_i ^ rs2_i;
    end else if (op_i[OP_SLT]) begin
      res = data_t'(lt);
    end
  end

  // Zero when idle so results can be ORed in exe
  assign data_o = alu_en_i ? res : '0;

endmodule

/* source/shifter.sv */
`timescale 1ns/10ps
`include "exe_config.svh"

module shifter (
  input  logic           sft_en_i,
  input  exe_pkg::data_t rs1_i,
  input  exe_pkg::data_t rs2_i,
  input  exe_pkg::op_t   op_i,
  output exe_pkg::data_t data_o
);

  import exe_pkg::*;

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [SHAMT_W-1:0] shamt;
  data_t              res;

  // Shift amount from the low bits of rs2
  assign shamt = rs2_i[SHAMT_W-1:0];

  always_comb begin
    res = '0;
    if (op_i[OP_SLL]) begin
      res = rs1_i << shamt;
    end else if (op_i[OP_SRL]) begin
      res = rs1_i >> shamt;
    end else if (op_i[OP_SRA]) begin
      // Arithmetic shift keeps the sign bit
      res = data_t'($signed(rs1_i) >>> shamt);
    end
  end

  assign data_o = sft_en_i ? res : '0;

endmodule

/* source/bu.sv */
`timescale 1ns/10ps

module bu (
  input  logic           bu_en_i,
  input  exe_pkg::data_t pc_i,
  input  exe_pkg::data_t rs1_i,
  input  exe_pkg::data_t rs2_i,
  input  exe_pkg::data_t imm_i,
  input  logic           unsign_i,
  input  exe_pkg::op_t   op_i,
  output logic           branch_v_o,
  output exe_pkg::data_t pc_nxt_o,
  output exe_pkg::data_t data_o
);

  import exe_pkg::*;

  logic  eq;
  logic  lt;
  logic  jump;
  logic  taken;
  data_t jalr_tgt;

  // --------------------------------------------------
  // Condition evaluation
  // --------------------------------------------------
  assign eq = rs1_i == rs2_i;

  always_comb begin
    if (unsign_i) begin
      lt = rs1_i < rs2_i;
    end else begin
      lt = $signed(rs1_i) < $signed(rs2_i);
    end
  end

  assign jump  = op_i[OP_JAL] | op_i[OP_JALR];
  assign taken = (op_i[OP_BEQ] &  eq)
               | (op_i[OP_BNE] & ~eq)
               | (op_i[OP_BLT] &  lt)
               | (op_i[OP_BGE] & ~lt)
               | jump;

  assign branch_v_o = bu_en_i & taken;

  // --------------------------------------------------
  // Target and link value
  // --------------------------------------------------
  // JALR target has bit 0 forced low
  assign jalr_tgt = (rs1_i + imm_i) & ~data_t'(1);
  assign pc_nxt_o = op_i[OP_JALR] ? jalr_tgt : pc_i + imm_i;

  // Return address for jumps only
  assign data_o = (bu_en_i & jump) ? pc_i + data_t'(4) : '0;

  // Decode hands over a single branch operation
  always_comb begin
    if (bu_en_i) begin
      a_one_branch_op: assert final ($onehot(op_i[OP_JALR:OP_BEQ]))
        else $error("bu: enabled without a single branch operation");
    end
  end

endmodule

/* source/lsu.sv */
`timescale 1ns/10ps

module lsu (
  input  logic           lsu_en_i,
  input  exe_pkg::data_t rs1_i,
  input  exe_pkg::data_t rs2_i,
  input  exe_pkg::data_t imm_i,
  input  exe_pkg::size_t size_i,
  input  logic           unsign_i,
  input  exe_pkg::data_t rdata_i,
  output exe_pkg::data_t adr_o,
  output exe_pkg::be_t   be_o,
  output exe_pkg::data_t wdata_o,
  output exe_pkg::data_t data_o
);

  import exe_pkg::*;

  data_t      adr;
  be_t        be;
  logic [7:0] lane_b;
  logic [15:0] lane_h;
  data_t      ld_data;

  // Effective address
  assign adr   = rs1_i + imm_i;
  assign adr_o = adr;

  // --------------------------------------------------
  // Store path
  // --------------------------------------------------
  always_comb begin
    case (size_i)
      SIZE_B: begin
        be      = be_t'(4'b0001 << adr[1:0]);
        wdata_o = {4{rs2_i[7:0]}};
      end
      SIZE_H: begin
        be      = adr[1] ? 4'b1100 : 4'b0011;
        wdata_o = {2{rs2_i[15:0]}};
      end
      default: begin
        be      = 4'b1111;
        wdata_o = rs2_i;
      end
    endcase
  end

  assign be_o = lsu_en_i ? be : '0;

  // --------------------------------------------------
  // Load path
  // --------------------------------------------------
  // Pick the addressed lane out of the word
  assign lane_b = rdata_i[{adr[1:0], 3'b000} +: 8];
  assign lane_h = adr[1] ? rdata_i[31:16] : rdata_i[15:0];

  always_comb begin
    case (size_i)
      SIZE_B:  ld_data = unsign_i ? data_t'(lane_b) : data_t'($signed(lane_b));
      SIZE_H:  ld_data = unsign_i ? data_t'(lane_h) : data_t'($signed(lane_h));
      default: ld_data = rdata_i;
    endcase
  end

  assign data_o = lsu_en_i ? ld_data : '0;

  // No misaligned access reaches memory
  always_comb begin
    if (lsu_en_i) begin
      a_aligned: assert final ((size_i != SIZE_W || adr[1:0] == 2'b00) &&
                               (size_i != SIZE_H || !adr[0]))
        else $error("lsu: misaligned access at %h", adr);
    end
  end

endmodule

/* source/exe.sv */
`timescale 1ns/10ps

module exe (
  input  logic              clk,
  input  logic              reset_n,
  // Decoded instruction
  input  exe_pkg::data_t    pc_i,
  input  exe_pkg::data_t    rs1_data_i,
  input  exe_pkg::data_t    rs2_data_i,
  input  exe_pkg::data_t    imm_i,
  input  exe_pkg::unit_t    unit_i,
  input  exe_pkg::op_t      op_i,
  input  exe_pkg::size_t    size_i,
  input  logic              unsign_i,
  input  logic              rd_v_i,
  input  exe_pkg::reg_adr_t rd_adr_i,
  // Data memory
  input  exe_pkg::data_t    mem_rdata_i,
  output exe_pkg::data_t    mem_adr_o,
  output logic              mem_we_o,
  output exe_pkg::be_t      mem_be_o,
  output exe_pkg::data_t    mem_wdata_o,
  // Forwarding
  output logic              fwd_v_o,
  output exe_pkg::reg_adr_t fwd_adr_o,
  output exe_pkg::data_t    fwd_data_o,
  // Write-back
  output logic              wbk_v_o,
  output exe_pkg::reg_adr_t wbk_adr_o,
  output exe_pkg::data_t    wbk_data_o,
  // Redirect
  output logic              flush_v_o,
  output exe_pkg::data_t    flush_pc_o
);

  import exe_pkg::*;

  logic     flush_q;
  logic     flush_dly_q;
  logic     kill;
  logic     alu_en;
  logic     sft_en;
  logic     bu_en;
  logic     lsu_en;
  data_t    alu_data;
  data_t    sft_data;
  data_t    bu_data;
  data_t    lsu_data;
  logic     branch_v;
  data_t    branch_pc;
  logic     rd_v;
  data_t    res_data;
  logic     wbk_v_q;
  reg_adr_t wbk_adr_q;
  data_t    wbk_data_q;
  data_t    flush_pc_q;

  // --------------------------------------------------
  // Unit enables
  // --------------------------------------------------
  // Two shadow cycles after a taken branch are dropped
  assign kill   = flush_q | flush_dly_q;
  assign alu_en = unit_i[UNIT_ALU] & ~kill;
  assign sft_en = unit_i[UNIT_SFT] & ~kill;
  assign bu_en  = unit_i[UNIT_BU]  & ~kill;
  assign lsu_en = unit_i[UNIT_LSU] & ~kill;
  assign rd_v   = rd_v_i & ~kill;

  alu i_alu (
    .alu_en_i (alu_en),
    .rs1_i    (rs1_data_i),
    .rs2_i    (rs2_data_i),
    .unsign_i (unsign_i),
    .op_i     (op_i),
    .data_o   (alu_data)
  );

  shifter i_shifter (
    .sft_en_i (sft_en),
    .rs1_i    (rs1_data_i),
    .rs2_i    (rs2_data_i),
    .op_i     (op_i),
    .data_o   (sft_data)
  );

  bu i_bu (
    .bu_en_i    (bu_en),
    .pc_i       (pc_i),
    .rs1_i      (rs1_data_i),
    .rs2_i      (rs2_data_i),
    .imm_i      (imm_i),
    .unsign_i   (unsign_i),
    .op_i       (op_i),
    .branch_v_o (branch_v),
    .pc_nxt_o   (branch_pc),
    .data_o     (bu_data)
  );

  lsu i_lsu (
    .lsu_en_i (lsu_en),
    .rs1_i    (rs1_data_i),
    .rs2_i    (rs2_data_i),
    .imm_i    (imm_i),
    .size_i   (size_i),
    .unsign_i (unsign_i),
    .rdata_i  (mem_rdata_i),
    .adr_o    (mem_adr_o),
    .be_o     (mem_be_o),
    .wdata_o  (mem_wdata_o),
    .data_o   (lsu_data)
  );

  // Store strobe, loads reuse the same port
  assign mem_we_o = lsu_en & op_i[OP_ST];

  // --------------------------------------------------
  // Result and forwarding
  // --------------------------------------------------
  // Idle units drive zero
  assign res_data = alu_data | sft_data | bu_data | lsu_data;

  assign fwd_v_o    = rd_v;
  assign fwd_adr_o  = rd_adr_i;
  assign fwd_data_o = res_data;

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wbk_v_q     <= 1'b0;
      flush_q     <= 1'b0;
      flush_dly_q <= 1'b0;
    end else begin
      wbk_v_q     <= rd_v;
      flush_q     <= branch_v;
      flush_dly_q <= flush_q;
    end
  end

  always_ff @(posedge clk) begin
    wbk_adr_q  <= rd_adr_i;
    wbk_data_q <= res_data;
    // Target held until the next taken branch
    if (branch_v) begin
      flush_pc_q <= branch_pc;
    end
  end

  assign wbk_v_o    = wbk_v_q;
  assign wbk_adr_o  = wbk_adr_q;
  assign wbk_data_o = wbk_data_q;
  assign flush_v_o  = flush_q;
  assign flush_pc_o = flush_pc_q;

  // The instruction in a flush cycle never reaches write-back
  a_no_wbk_after_flush: assert property (@(posedge clk) disable iff (!reset_n)
    flush_v_o |=> !wbk_v_o)
    else $error("exe: write-back of a cancelled instruction");

endmodule

/* source/dmem.sv */
`timescale 1ns/10ps
`include "exe_config.svh"

module dmem (
  input  logic           clk,
  input  exe_pkg::data_t adr_i,
  input  logic           we_i,
  input  exe_pkg::be_t   be_i,
  input  exe_pkg::data_t wdata_i,
  output exe_pkg::data_t rdata_o
);

  import exe_pkg::*;

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  data_t            mem [`DMEM_WORDS];
  logic [IDX_W-1:0] idx;

  // --------------------------------------------------
  // Word index from the byte address
  // --------------------------------------------------
  assign idx = adr_i[IDX_W+1:2];

  // Read path, same cycle as the address
  assign rdata_o = mem[idx];

  // Byte lanes written independently
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be_i[b]) begin
          mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

/* source/exe_top.sv */
`timescale 1ns/10ps

module exe_top (
  input  logic              clk,
  input  logic              reset_n,
  input  exe_pkg::data_t    pc_i,
  input  exe_pkg::data_t    rs1_data_i,
  input  exe_pkg::data_t    rs2_data_i,
  input  exe_pkg::data_t    imm_i,
  input  exe_pkg::unit_t    unit_i,
  input  exe_pkg::op_t      op_i,
  input  exe_pkg::size_t    size_i,
  input  logic              unsign_i,
  input  logic              rd_v_i,
  input  exe_pkg::reg_adr_t rd_adr_i,
  output logic              fwd_v_o,
  output exe_pkg::reg_adr_t fwd_adr_o,
  output exe_pkg::data_t    fwd_data_o,
  output logic              wbk_v_o,
  output exe_pkg::reg_adr_t wbk_adr_o,
  output exe_pkg::data_t    wbk_data_o,
  output logic              flush_v_o,
  output exe_pkg::data_t    flush_pc_o
);

  import exe_pkg::*;

  // Memory port between execute and data memory
  data_t mem_adr;
  logic  mem_we;
  be_t   mem_be;
  data_t mem_wdata;
  data_t mem_rdata;

  exe i_exe (
    .clk         (clk),
    .reset_n     (reset_n),
    .pc_i        (pc_i),
    .rs1_data_i  (rs1_data_i),
    .rs2_data_i  (rs2_data_i),
    .imm_i       (imm_i),
    .unit_i      (unit_i),
    .op_i        (op_i),
    .size_i      (size_i),
    .unsign_i    (unsign_i),
    .rd_v_i      (rd_v_i),
    .rd_adr_i    (rd_adr_i),
    .mem_rdata_i (mem_rdata),
    .mem_adr_o   (mem_adr),
    .mem_we_o    (mem_we),
    .mem_be_o    (mem_be),
    .mem_wdata_o (mem_wdata),
    .fwd_v_o     (fwd_v_o),
    .fwd_adr_o   (fwd_adr_o),
    .fwd_data_o  (fwd_data_o),
    .wbk_v_o     (wbk_v_o),
    .wbk_adr_o   (wbk_adr_o),
    .wbk_data_o  (wbk_data_o),
    .flush_v_o   (flush_v_o),
    .flush_pc_o  (flush_pc_o)
  );

  dmem i_dmem (
    .clk     (clk),
    .adr_i   (mem_adr),
    .we_i    (mem_we),
    .be_i    (mem_be),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

/* sim/exe_tb.sv */
`timescale 1ns/10ps

module exe_tb;

  import exe_pkg::*;

  typedef struct packed {
    data_t    pc;
    data_t    rs1;
    data_t    rs2;
    data_t    imm;
    unit_t    unit;
    op_t      op;
    size_t    size;
    logic     unsign;
    logic     rd_v;
    reg_adr_t rd;
    logic     exp_v;
    data_t    exp_data;
    logic     exp_flush;
    data_t    exp_pc;
  } entry_t;

  logic     clk;
  logic     reset_n;
  data_t    pc;
  data_t    rs1_data;
  data_t    rs2_data;
  data_t    imm;
  unit_t    unit;
  op_t      op;
  size_t    size;
  logic     unsign;
  logic     rd_v;
  reg_adr_t rd_adr;
  logic     fwd_v_o;
  reg_adr_t fwd_adr_o;
  data_t    fwd_data_o;
  logic     wbk_v_o;
  reg_adr_t wbk_adr_o;
  data_t    wbk_data_o;
  logic     flush_v_o;
  data_t    flush_pc_o;

  entry_t tbl[$];
  string  names[$];
  int     entry_err[$];
  data_t  next_pc;
  bit     table_ready;
  int     errors;
  int     n_ok;
  int     n_bad;

  exe_top i_exe_top (
    .clk        (clk),
    .reset_n    (reset_n),
    .pc_i       (pc),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .imm_i      (imm),
    .unit_i     (unit),
    .op_i       (op),
    .size_i     (size),
    .unsign_i   (unsign),
    .rd_v_i     (rd_v),
    .rd_adr_i   (rd_adr),
    .fwd_v_o    (fwd_v_o),
    .fwd_adr_o  (fwd_adr_o),
    .fwd_data_o (fwd_data_o),
    .wbk_v_o    (wbk_v_o),
    .wbk_adr_o  (wbk_adr_o),
    .wbk_data_o (wbk_data_o),
    .flush_v_o  (flush_v_o),
    .flush_pc_o (flush_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------------------------------------
  // Table construction
  // --------------------------------------------------
  function automatic unit_t unit_sel(int idx);
    return unit_t'(1) << idx;
  endfunction

  function automatic op_t op_sel(int idx);
    return op_t'(1) << idx;
  endfunction

  function automatic entry_t make_entry(unit_t u, op_t o, data_t a, data_t b, data_t im,
                                        size_t sz, logic uns, logic rv, reg_adr_t rd,
                                        data_t exp_data, logic exp_flush, data_t exp_pc);
    entry_t e;
    e           = '0;
    e.unit      = u;
    e.op        = o;
    e.rs1       = a;
    e.rs2       = b;
    e.imm       = im;
    e.size      = sz;
    e.unsign    = uns;
    e.rd_v      = rv;
    e.rd        = rd;
    e.exp_data  = exp_data;
    e.exp_flush = exp_flush;
    e.exp_pc    = exp_pc;
    return e;
  endfunction

  function automatic entry_t alu_entry(int o, data_t a, data_t b, logic uns, reg_adr_t rd,
                                       data_t exp_data);
    return make_entry(unit_sel(UNIT_ALU), op_sel(o), a, b, '0, SIZE_W, uns, 1'b1, rd,
                      exp_data, 1'b0, '0);
  endfunction

  function automatic entry_t sft_entry(int o, data_t a, data_t b, reg_adr_t rd,
                                       data_t exp_data);
    return make_entry(unit_sel(UNIT_SFT), op_sel(o), a, b, '0, SIZE_W, 1'b0, 1'b1, rd,
                      exp_data, 1'b0, '0);
  endfunction

  // All accesses are based at 0x200, stores have no destination
  function automatic entry_t mem_entry(logic st, data_t off, data_t wdata, size_t sz,
                                       logic uns, reg_adr_t rd, data_t exp_data);
    return make_entry(unit_sel(UNIT_LSU), st ? op_sel(OP_ST) : op_t'(0), 32'h200, wdata,
                      off, sz, uns, ~st, rd, exp_data, 1'b0, '0);
  endfunction

  function automatic entry_t branch_entry(int o, data_t a, data_t b, data_t im, logic uns,
                                          logic taken, data_t target);
    return make_entry(unit_sel(UNIT_BU), op_sel(o), a, b, im, SIZE_W, uns, 1'b0, '0, '0,
                      taken, target);
  endfunction

  // Link value is the address after the jump
  function automatic entry_t jump_entry(int o, data_t a, data_t im, reg_adr_t rd,
                                        data_t target);
    return make_entry(unit_sel(UNIT_BU), op_sel(o), a, '0, im, SIZE_W, 1'b0, 1'b1, rd,
                      next_pc + 32'd4, 1'b1, target);
  endfunction

  task automatic add_entry(string name, entry_t e, logic cancelled);
    e.pc    = next_pc;
    e.exp_v = e.rd_v & ~cancelled;
    if (cancelled) begin
      e.exp_flush = 1'b0;
    end
    tbl.push_back(e);
    names.push_back(name);
    entry_err.push_back(0);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic build_table();
    data_t      a;
    data_t      b;
    data_t      neg;
    data_t      pos;
    logic [4:0] sh;
    entry_t     idle;

    idle    = make_entry('0, '0, '0, '0, '0, SIZE_B, 1'b0, 1'b0, '0, '0, 1'b0, '0);
    next_pc = 32'h0000_0100;
    a       = $urandom();
    b       = $urandom();
    add_entry("alu add", alu_entry(OP_ADD, a, b, 1'b0, 5'd1, a + b), 1'b0);
    add_entry("alu sub", alu_entry(OP_SUB, a, b, 1'b0, 5'd2, a - b), 1'b0);
    add_entry("alu and", alu_entry(OP_AND, a, b, 1'b0, 5'd3, a & b), 1'b0);
    add_entry("alu or", alu_entry(OP_OR, a, b, 1'b0, 5'd4, a | b), 1'b0);
    add_entry("alu xor", alu_entry(OP_XOR, a, b, 1'b0, 5'd5, a ^ b), 1'b0);
    // Negative against positive splits signed from unsigned
    neg = $urandom() | 32'h8000_0000;
    pos = $urandom() & 32'h7fff_ffff;
    add_entry("alu slt signed", alu_entry(OP_SLT, neg, pos, 1'b0, 5'd6, 32'd1), 1'b0);
    add_entry("alu slt unsigned", alu_entry(OP_SLT, neg, pos, 1'b1, 5'd7, 32'd0), 1'b0);
    a  = $urandom();
    b  = $urandom();
    sh = b[4:0];
    add_entry("shift sll", sft_entry(OP_SLL, a, b, 5'd8, a << sh), 1'b0);
    add_entry("shift srl", sft_entry(OP_SRL, a, b, 5'd9, a >> sh), 1'b0);
    add_entry("shift sra", sft_entry(OP_SRA, neg, b, 5'd10,
                                     (neg >> sh) | ~(32'hffff_ffff >> sh)), 1'b0);

    // --------------------------------------------------
    // Stores merge into the word at 0x210
    // --------------------------------------------------
    add_entry("store word", mem_entry(1'b1, 32'h10, 32'h1122_3344, SIZE_W, 1'b0, '0, '0), 1'b0);
    add_entry("store half", mem_entry(1'b1, 32'h12, 32'h0000_a5b6, SIZE_H, 1'b0, '0, '0), 1'b0);
    add_entry("store byte", mem_entry(1'b1, 32'h11, 32'h0000_00c7, SIZE_B, 1'b0, '0, '0), 1'b0);
    add_entry("load word", mem_entry(1'b0, 32'h10, '0, SIZE_W, 1'b0, 5'd11, 32'ha5b6_c744),
              1'b0);
    add_entry("load byte sx", mem_entry(1'b0, 32'h11, '0, SIZE_B, 1'b0, 5'd12, 32'hffff_ffc7),
              1'b0);
    add_entry("load byte zx", mem_entry(1'b0, 32'h11, '0, SIZE_B, 1'b1, 5'd13, 32'h0000_00c7),
              1'b0);
    add_entry("load half sx", mem_entry(1'b0, 32'h12, '0, SIZE_H, 1'b0, 5'd14, 32'hffff_a5b6),
              1'b0);
    add_entry("load half zx", mem_entry(1'b0, 32'h12, '0, SIZE_H, 1'b1, 5'd15, 32'h0000_a5b6),
              1'b0);
    add_entry("load byte pos", mem_entry(1'b0, 32'h10, '0, SIZE_B, 1'b0, 5'd16, 32'h0000_0044),
              1'b0);
    add_entry("store guard", mem_entry(1'b1, 32'h20, 32'h5a5a_0ff0, SIZE_W, 1'b0, '0, '0), 1'b0);

    // --------------------------------------------------
    // Branches and jumps
    // --------------------------------------------------
    add_entry("beq not taken", branch_entry(OP_BEQ, 32'd5, 32'd6, 32'h40, 1'b0, 1'b0, '0), 1'b0);
    add_entry("bne taken", branch_entry(OP_BNE, 32'd5, 32'd6, 32'h80, 1'b0, 1'b1,
                                        next_pc + 32'h80), 1'b0);
    add_entry("shadow add 1", alu_entry(OP_ADD, 32'd1, 32'd2, 1'b0, 5'd17, 32'd3), 1'b1);
    add_entry("shadow add 2", alu_entry(OP_ADD, 32'd3, 32'd4, 1'b0, 5'd18, 32'd7), 1'b1);
    add_entry("add after shadow", alu_entry(OP_ADD, 32'd5, 32'd6, 1'b0, 5'd19, 32'd11), 1'b0);
    add_entry("blt taken", branch_entry(OP_BLT, 32'hffff_fff0, 32'd4, 32'hffff_ffe0, 1'b0,
                                        1'b1, next_pc - 32'h20), 1'b0);
    add_entry("beq in shadow", branch_entry(OP_BEQ, 32'd7, 32'd7, 32'h40, 1'b0, 1'b1,
                                            next_pc + 32'h40), 1'b1);
    add_entry("store in shadow", mem_entry(1'b1, 32'h20, 32'hdead_beef, SIZE_W, 1'b0, '0, '0),
              1'b1);
    add_entry("load guard", mem_entry(1'b0, 32'h20, '0, SIZE_W, 1'b0, 5'd20, 32'h5a5a_0ff0),
              1'b0);
    add_entry("bge unsigned", branch_entry(OP_BGE, 32'd3, 32'hffff_ffff, 32'h40, 1'b1, 1'b0,
                                           '0), 1'b0);
    add_entry("jal", jump_entry(OP_JAL, '0, 32'h100, 5'd21, next_pc + 32'h100), 1'b0);
    add_entry("shadow or", alu_entry(OP_OR, 32'd1, 32'd2, 1'b0, 5'd22, 32'd3), 1'b1);
    add_entry("shadow xor", alu_entry(OP_XOR, 32'd1, 32'd3, 1'b0, 5'd23, 32'd2), 1'b1);
    // Target 0x1245 has bit 0 cleared
    add_entry("jalr", jump_entry(OP_JALR, 32'h1235, 32'h10, 5'd24, 32'h1244), 1'b0);
    add_entry("bubble 1", idle, 1'b1);
    add_entry("bubble 2", idle, 1'b1);
    add_entry("or after jalr", alu_entry(OP_OR, 32'h0f0, 32'h00f, 1'b0, 5'd25, 32'h0ff), 1'b0);
  endtask

  // --------------------------------------------------
  // Drive and check
  // --------------------------------------------------
  task automatic drive_entry(entry_t e);
    pc       = e.pc;
    rs1_data = e.rs1;
    rs2_data = e.rs2;
    imm      = e.imm;
    unit     = e.unit;
    op       = e.op;
    size     = e.size;
    unsign   = e.unsign;
    rd_v     = e.rd_v;
    rd_adr   = e.rd;
  endtask

  task automatic count_error(int idx);
    errors++;
    entry_err[idx]++;
  endtask

  task automatic check_forward(int idx);
    entry_t e;
    e = tbl[idx];
    if (fwd_v_o !== e.exp_v) begin
      $display("FAILED %0t: %s fwd_v_o %b, expected %b", $time, names[idx], fwd_v_o, e.exp_v);
      count_error(idx);
    end
    if (e.exp_v && fwd_adr_o !== e.rd) begin
      $display("FAILED %0t: %s fwd_adr_o %0d, expected %0d", $time, names[idx], fwd_adr_o,
               e.rd);
      count_error(idx);
    end
    if (e.exp_v && fwd_data_o !== e.exp_data) begin
      $display("FAILED %0t: %s fwd_data_o %h, expected %h", $time, names[idx], fwd_data_o,
               e.exp_data);
      count_error(idx);
    end
  endtask

  // One cycle after the entry, then the entry is reported
  task automatic check_retire(int idx);
    entry_t e;
    e = tbl[idx];
    if (wbk_v_o !== e.exp_v) begin
      $display("FAILED %0t: %s wbk_v_o %b, expected %b", $time, names[idx], wbk_v_o, e.exp_v);
      count_error(idx);
    end
    if (e.exp_v && (wbk_adr_o !== e.rd || wbk_data_o !== e.exp_data)) begin
      $display("FAILED %0t: %s write-back r%0d=%h, expected r%0d=%h", $time, names[idx],
               wbk_adr_o, wbk_data_o, e.rd, e.exp_data);
      count_error(idx);
    end
    if (flush_v_o !== e.exp_flush) begin
      $display("FAILED %0t: %s flush_v_o %b, expected %b", $time, names[idx], flush_v_o,
               e.exp_flush);
      count_error(idx);
    end
    if (e.exp_flush && flush_pc_o !== e.exp_pc) begin
      $display("FAILED %0t: %s flush_pc_o %h, expected %h", $time, names[idx], flush_pc_o,
               e.exp_pc);
      count_error(idx);
    end
    if (entry_err[idx] == 0) begin
      n_ok++;
      $display("entry %0d %s: ok", idx, names[idx]);
    end else begin
      n_bad++;
      $display("entry %0d %s: %0d mismatches", idx, names[idx], entry_err[idx]);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    int unsigned seed_val;
    int          n;
    entry_t      idle;

    seed_val    = $urandom(32'h3c665f2c);
    errors      = 0;
    n_ok        = 0;
    n_bad       = 0;
    table_ready = 1'b0;
    reset_n     = 1'b0;
    idle        = '0;
    drive_entry(idle);
    build_table();
    n           = tbl.size();
    table_ready = 1'b1;

    repeat (5) @(posedge clk);
    #1 reset_n = 1'b1;
    @(negedge clk);
    if (wbk_v_o !== 1'b0 || flush_v_o !== 1'b0 || fwd_v_o !== 1'b0) begin
      $display("FAILED %0t: outputs not idle after reset", $time);
      errors++;
    end

    for (int i = 0; i <= n; i++) begin
      @(posedge clk);
      #1;
      if (i < n) begin
        drive_entry(tbl[i]);
      end else begin
        drive_entry(idle);
      end
      #49;
      if (i < n) begin
        check_forward(i);
      end
      if (i > 0) begin
        check_retire(i - 1);
      end
    end

    $display("summary: %0d entries, %0d ok, %0d failing, %0d errors", n, n_ok, n_bad, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_ready);
    #((tbl.size() + 20) * 100);
    $display("timeout: run did not finish within %0d clock cycles", tbl.size() + 20);
    $display("test failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
source/exe_pkg.sv
source/alu.sv
source/shifter.sv
source/bu.sv
source/lsu.sv
source/exe.sv
source/dmem.sv
source/exe_top.sv
sim/exe_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

TOP  := exe_tb
SRCS := $(filter-out +incdir+%,$(shell cat flist.f))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, the header or the file list changes
$(BIN): flist.f $(SRCS) include/exe_config.svh
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) \
		-f flist.f -o V$(TOP)

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
